//--- verilog/mipsPkg.sv
// Shared widths, opcode and function encodings, ALU and forwarding selects
// Pipeline stage bundles for the five-stage MIPS core
`default_nettype none

package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [dataWidth-1:0] word;
	typedef logic [regAddrWidth-1:0] regAddr;

	typedef enum logic [5:0] {
		rType = 6'b000000,
		lw    = 6'b100011,
		sw    = 6'b101011,
		beq   = 6'b000100,
		addi  = 6'b001000
	} opcode;

	typedef enum logic [5:0] {
		fAdd = 6'b100000,
		fSub = 6'b100010,
		fAnd = 6'b100100,
		fOr  = 6'b100101,
		fSlt = 6'b101010
	} functCode;

	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluControl;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		fwdReg       = 2'b00,
		fwdWriteback = 2'b01,
		fwdMemory    = 2'b10
	} forwardSel;

	// ******************************************************************
	// Stage bundles that read as a bubble when all zero
	// ******************************************************************

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic branch;
		aluControl aluCtrl;
	} ctrlSignals;

	typedef struct packed {
		ctrlSignals ctrl;
		word readDataA;
		word readDataB;
		regAddr rs;
		regAddr rt;
		regAddr rd;
		word imm;
		word pcPlus4;
	} decodeExecBundle;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic branchTaken;
		word aluOut;
		word writeData;
		regAddr writeReg;
		word branchTarget;
	} execMemBundle;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		word readData;
		word aluOut;
		regAddr writeReg;
	} memWbBundle;

endpackage

`default_nettype wire

//--- verilog/regFile.sv
// Register file with two combinational reads and one falling-edge write
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic           clk,
	input  mipsPkg::regAddr readAddrA,
	input  mipsPkg::regAddr readAddrB,
	output mipsPkg::word    readDataA,
	output mipsPkg::word    readDataB,
	input  logic           writeEnable,
	input  mipsPkg::regAddr writeAddr,
	input  mipsPkg::word    writeValue
);
	import mipsPkg::*;

	word regs [1:31];                                   // Register zero is not stored

	// Writing on the falling edge lets decode see a writeback of the same cycle
	always_ff @(negedge clk)
	begin
		if (writeEnable && (writeAddr != '0))
		begin
			regs[writeAddr] <= writeValue;
		end
	end

	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- verilog/mipsDecode.sv
// Fetch-to-decode register, instruction field split and control decode
// Sign extension and the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none

module mipsDecode (
	input  logic                     clk,
	input  logic                     reset,
	input  mipsPkg::word             instr,
	input  mipsPkg::word             pcPlus4,
	input  logic                     stall,
	input  logic                     flush,
	input  logic                     flushNext,
	output mipsPkg::regAddr          rs,
	output mipsPkg::regAddr          rt,
	input  mipsPkg::word             readDataA,
	input  mipsPkg::word             readDataB,
	output mipsPkg::decodeExecBundle decoded
);
	import mipsPkg::*;

	word instrD;
	word pcPlus4D;
	opcode opField;
	functCode functField;
	ctrlSignals ctrl;
	decodeExecBundle nextBundle;

	// ******************************************************************
	// Fetch-to-decode register
	// ******************************************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			instrD <= '0;
			pcPlus4D <= '0;
		end
		else if (flush)
		begin
			instrD <= '0;                                    // Zero word decodes as a bubble
			pcPlus4D <= '0;
		end
		else if (!stall)
		begin
			instrD <= instr;
			pcPlus4D <= pcPlus4;
		end
	end

	assign opField = opcode'(instrD[31:26]);
	assign functField = functCode'(instrD[5:0]);
	assign rs = instrD[25:21];
	assign rt = instrD[20:16];

	// Main and ALU decode in one table
	always_comb
	begin
		ctrl = '0;
		case (opField)
			rType:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (functField)
					fAdd:    ctrl.aluCtrl = aluAdd;
					fSub:    ctrl.aluCtrl = aluSub;
					fAnd:    ctrl.aluCtrl = aluAnd;
					fOr:     ctrl.aluCtrl = aluOr;
					fSlt:    ctrl.aluCtrl = aluSlt;
					default: ctrl = '0;                    // Unknown function is a bubble
				endcase
			end
			lw:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtrl = aluAdd;
			end
			sw:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtrl = aluAdd;
			end
			beq:
			begin
				ctrl.branch = 1'b1;
				ctrl.aluCtrl = aluSub;                     // Zero flag gives equality
			end
			addi:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtrl = aluAdd;
			end
			default: ctrl = '0;
		endcase
	end

	always_comb
	begin
		nextBundle.ctrl = ctrl;
		nextBundle.readDataA = readDataA;
		nextBundle.readDataB = readDataB;
		nextBundle.rs = instrD[25:21];
		nextBundle.rt = instrD[20:16];
		nextBundle.rd = instrD[15:11];
		nextBundle.imm = {{16{instrD[15]}}, instrD[15:0]};     // Sign extend
		nextBundle.pcPlus4 = pcPlus4D;
	end

	// ******************************************************************
	// Decode-to-execute register
	// ******************************************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			decoded <= '0;
		else if (flushNext)
			decoded <= '0;                                   // Bubble for load-use or branch
		else
			decoded <= nextBundle;
	end

endmodule

`default_nettype wire

//--- verilog/mipsExecute.sv
// Forwarding muxes, ALU and branch decision
// Execute-to-memory register
`timescale 1ns/1ps
`default_nettype none

module mipsExecute (
	input  logic                     clk,
	input  logic                     reset,
	input  mipsPkg::decodeExecBundle decoded,
	input  mipsPkg::forwardSel       forwardA,
	input  mipsPkg::forwardSel       forwardB,
	input  mipsPkg::word             memAluOut,
	input  mipsPkg::word             wbResult,
	input  logic                     flush,
	output mipsPkg::execMemBundle    executed,
	output mipsPkg::regAddr          writeRegE
);
	import mipsPkg::*;

	word srcA;
	word srcB;
	word writeDataE;
	word aluResult;
	word branchTarget;
	logic zero;
	execMemBundle nextBundle;

	function automatic word fwdMux(input forwardSel sel, input word regValue,
		input word wbValue, input word memValue);
		case (sel)
			fwdMemory:    return memValue;
			fwdWriteback: return wbValue;
			default:      return regValue;
		endcase
	endfunction

	// ******************************************************************
	// Operand selection
	// ******************************************************************

	assign srcA = fwdMux(forwardA, decoded.readDataA, wbResult, memAluOut);
	assign writeDataE = fwdMux(forwardB, decoded.readDataB, wbResult, memAluOut);
	assign srcB = decoded.ctrl.aluSrc ? decoded.imm : writeDataE;

	always_comb
	begin
		case (decoded.ctrl.aluCtrl)
			aluAdd:  aluResult = srcA + srcB;
			aluSub:  aluResult = srcA - srcB;
			aluAnd:  aluResult = srcA & srcB;
			aluOr:   aluResult = srcA | srcB;
			aluSlt:  aluResult = ($signed(srcA) < $signed(srcB)) ? word'(1) : '0;  // Signed compare
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0);
	assign branchTarget = decoded.pcPlus4 + {decoded.imm[29:0], 2'b00};  // Word offset
	assign writeRegE = decoded.ctrl.regDst ? decoded.rd : decoded.rt;

	always_comb
	begin
		nextBundle.regWrite = decoded.ctrl.regWrite;
		nextBundle.memToReg = decoded.ctrl.memToReg;
		nextBundle.memWrite = decoded.ctrl.memWrite;
		nextBundle.branchTaken = decoded.ctrl.branch & zero;
		nextBundle.aluOut = aluResult;
		nextBundle.writeData = writeDataE;                   // Forwarded store data
		nextBundle.writeReg = writeRegE;
		nextBundle.branchTarget = branchTarget;
	end

	// ******************************************************************
	// Execute-to-memory register
	// ******************************************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			executed <= '0;
		else if (flush)
			executed <= '0;                                  // Killed by a taken branch
		else
			executed <= nextBundle;
	end

endmodule

`default_nettype wire

//--- verilog/mipsResult.sv
// Memory-to-writeback register and writeback result select
`timescale 1ns/1ps
`default_nettype none

module mipsResult (
	input  logic                  clk,
	input  logic                  reset,
	input  mipsPkg::execMemBundle executed,
	input  mipsPkg::word          readData,
	output logic                  regWrite,
	output mipsPkg::regAddr       writeReg,
	output mipsPkg::word          result
);
	import mipsPkg::*;

	memWbBundle wb;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb <= '0;
		end
		else
		begin
			wb.regWrite <= executed.regWrite;
			wb.memToReg <= executed.memToReg;
			wb.readData <= readData;                         // Load data from the testbench memory
			wb.aluOut <= executed.aluOut;
			wb.writeReg <= executed.writeReg;
		end
	end

	assign regWrite = wb.regWrite;
	assign writeReg = wb.writeReg;
	assign result = wb.memToReg ? wb.readData : wb.aluOut;

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
// Forwarding selects, load-use stall and taken-branch flush
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  mipsPkg::regAddr   rsD,
	input  mipsPkg::regAddr   rtD,
	input  mipsPkg::regAddr   rsE,
	input  mipsPkg::regAddr   rtE,
	input  mipsPkg::regAddr   writeRegE,
	input  mipsPkg::regAddr   writeRegM,
	input  mipsPkg::regAddr   writeRegW,
	input  logic              memToRegE,
	input  logic              regWriteM,
	input  logic              regWriteW,
	input  logic              branchTakenM,
	output mipsPkg::forwardSel forwardA,
	output mipsPkg::forwardSel forwardB,
	output logic              stallFetch,
	output logic              stallDecode,
	output logic              flushDecode,
	output logic              flushExecute,
	output logic              flushMemory
);
	import mipsPkg::*;

	logic loadUse;

	function automatic forwardSel pickSource(input regAddr src, input regAddr wrM,
		input logic wrEnM, input regAddr wrW, input logic wrEnW);
		if ((src != '0) && wrEnM && (src == wrM))
			return fwdMemory;                                // Youngest value wins
		else if ((src != '0) && wrEnW && (src == wrW))
			return fwdWriteback;
		else
			return fwdReg;
	endfunction

	assign forwardA = pickSource(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign forwardB = pickSource(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	// Load in execute whose destination is read in decode
	assign loadUse = memToRegE && (writeRegE != '0) &&
		((rsD == writeRegE) || (rtD == writeRegE));

	// A taken branch overrides the stall
	assign stallFetch = loadUse & ~branchTakenM;
	assign stallDecode = loadUse & ~branchTakenM;
	assign flushDecode = branchTakenM;
	assign flushExecute = loadUse | branchTakenM;
	assign flushMemory = branchTakenM;

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
// Top level of the five-stage core with program counter and next-PC choice
// Stage, register file and hazard unit instances
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input  logic         clk,
	input  logic         reset,
	output mipsPkg::word pc,
	input  mipsPkg::word instr,
	output logic         memWrite,
	output mipsPkg::word dataAddr,
	output mipsPkg::word writeData,
	input  mipsPkg::word readData
);
	import mipsPkg::*;

	word pcPlus4;
	regAddr rsD;
	regAddr rtD;
	regAddr writeRegE;
	regAddr writeRegW;
	word regDataA;
	word regDataB;
	word resultW;
	logic regWriteW;
	decodeExecBundle decoded;
	execMemBundle executed;
	forwardSel forwardA;
	forwardSel forwardB;
	logic stallFetch;
	logic stallDecode;
	logic flushDecode;
	logic flushExecute;
	logic flushMemory;

	// ******************************************************************
	// Fetch
	// ******************************************************************

	assign pcPlus4 = pc + 32'd4;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pc <= '0;
		else if (executed.branchTaken)
			pc <= executed.branchTarget;                     // Branch resolved in memory
		else if (!stallFetch)
			pc <= pcPlus4;
	end

	mipsDecode decodeStage (.clk(clk), .reset(reset), .instr(instr), .pcPlus4(pcPlus4),
		.stall(stallDecode), .flush(flushDecode), .flushNext(flushExecute),
		.rs(rsD), .rt(rtD), .readDataA(regDataA), .readDataB(regDataB), .decoded(decoded));

	regFile regs (.clk(clk), .readAddrA(rsD), .readAddrB(rtD), .readDataA(regDataA),
		.readDataB(regDataB), .writeEnable(regWriteW), .writeAddr(writeRegW),
		.writeValue(resultW));

	mipsExecute executeStage (.clk(clk), .reset(reset), .decoded(decoded),
		.forwardA(forwardA), .forwardB(forwardB), .memAluOut(executed.aluOut),
		.wbResult(resultW), .flush(flushMemory), .executed(executed), .writeRegE(writeRegE));

	// Memory stage drives the data port directly
	assign memWrite = executed.memWrite;
	assign dataAddr = executed.aluOut;
	assign writeData = executed.writeData;

	mipsResult resultStage (.clk(clk), .reset(reset), .executed(executed),
		.readData(readData), .regWrite(regWriteW), .writeReg(writeRegW), .result(resultW));

	hazardUnit hazards (.rsD(rsD), .rtD(rtD), .rsE(decoded.rs), .rtE(decoded.rt),
		.writeRegE(writeRegE), .writeRegM(executed.writeReg), .writeRegW(writeRegW),
		.memToRegE(decoded.ctrl.memToReg), .regWriteM(executed.regWrite),
		.regWriteW(regWriteW), .branchTakenM(executed.branchTaken),
		.forwardA(forwardA), .forwardB(forwardB), .stallFetch(stallFetch),
		.stallDecode(stallDecode), .flushDecode(flushDecode),
		.flushExecute(flushExecute), .flushMemory(flushMemory));

endmodule

`default_nettype wire

//--- dv/mipsCoreChecker.sv
// Concurrent assertions on the core's PC and data-memory write port
// Bound into every mipsCore instance
`timescale 1ns/1ps
`default_nettype none

module mipsCoreChecker (
	input logic         clk,
	input logic         reset,
	input mipsPkg::word pc,
	input logic         memWrite,
	input logic         stallFetch
);
	int assertFails = 0;                                      // Read by the testbench summary

	memWriteInReset: assert property (@(posedge clk) reset |-> !memWrite)
	else
	begin
		assertFails++;
		$error("memWrite is high while reset is asserted");
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
	else
	begin
		assertFails++;
		$error("pc is not word aligned");
	end

	// A held fetch keeps the same address for the next cycle
	pcHeld: assert property (@(posedge clk) disable iff (reset) stallFetch |=> $stable(pc))
	else
	begin
		assertFails++;
		$error("pc moved during a load-use stall");
	end

endmodule

bind mipsCore mipsCoreChecker pipeCheck (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.memWrite(memWrite),
	.stallFetch(stallFetch)
);

`default_nettype wire

//--- include/mipsTbTasks.svh
// Instruction encoding helpers, program and store bookkeeping
// Directed tests for the pipelined core
`ifndef MIPS_TB_TASKS_SVH
`define MIPS_TB_TASKS_SVH

function automatic word rInstr(input functCode fn, input int rd, input int rs, input int rt);
	return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'b00000, fn};
endfunction

function automatic word iInstr(input opcode op, input int rt, input int rs, input int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic word signExt(input int imm);
	logic [15:0] low;
	low = 16'(imm);
	return {{16{low[15]}}, low};
endfunction

function automatic int randImm();
	return int'($urandom & 32'h0000FFFF);
endfunction

function automatic word sltOf(input word x, input word y);
	if (x[31] != y[31])
		return {31'd0, x[31]};                                // Only a negative x is smaller
	return (x < y) ? 32'd1 : 32'd0;                           // Same sign compares as unsigned
endfunction

task automatic newProgram();
	for (int i = 0; i < memWords; i++)
		imem[i] = iInstr(beq, 0, 0, -1);                      // Branch to itself
	progLen = 0;
	expAddr.delete();
	expData.delete();
endtask

task automatic addInstr(input word w);
	imem[progLen] = w;
	progLen++;
endtask

task automatic expectStore(input word addr, input word data);
	expAddr.push_back(addr);
	expData.push_back(data);
endtask

task automatic resetCore();
	@(posedge clk);
	#1;
	reset = 1'b1;
	for (int i = 0; i < resetCycles; i++)
		@(posedge clk);
	#1;
	reset = 1'b0;
endtask

task automatic waitStores(input int expected);
	int cycles;
	cycles = 0;
	while ((storeAddr.size() < expected) && (cycles < cycleLimit))
	begin
		@(posedge clk);
		#1;
		cycles++;
	end
	if (storeAddr.size() < expected)
	begin
		$display("Timed out after %0d cycles with %0d of %0d stores seen", cycles,
			storeAddr.size(), expected);
		testErrors++;
	end
	// A stray store would still be in the pipe
	cycles = 0;
	while (cycles < pipeDepth)
	begin
		@(posedge clk);
		#1;
		cycles++;
	end
endtask

task automatic checkStores();
	checkCount("store count", storeAddr.size(), expAddr.size());
	for (int i = 0; i < expAddr.size(); i++)
	begin
		if (i < storeAddr.size())
		begin
			checkWord($sformatf("dataAddr of store %0d", i), storeAddr[i], expAddr[i]);
			checkWord($sformatf("writeData of store %0d", i), storeData[i], expData[i]);
		end
	end
endtask

task automatic finishTest(input string name);
	$display("%s: %0d errors", name, testErrors);
	errorCount += testErrors;
	testErrors = 0;
	testCount++;
endtask

task automatic runProgram(input string name);
	resetCore();
	waitStores(expAddr.size());
	checkStores();
	finishTest(name);
endtask

// ********************************************************************
// Directed tests
// ********************************************************************

task automatic resetAndFirstStore();
	int immA;
	word a;
	immA = randImm();
	a = signExt(immA);
	newProgram();
	addInstr(iInstr(addi, 1, 0, immA));
	addInstr(iInstr(addi, 2, 1, 1));
	addInstr(rInstr(fAdd, 3, 1, 2));
	addInstr(iInstr(sw, 3, 0, 160));                          // Fetched in cycle 3
	expectStore(32'd160, a + a + 32'd1);
	resetCore();
	checkWord("pc", pc, 32'd0);
	waitStores(1);
	checkStores();
	if (storeCycle.size() > 0)
		checkCount("cycle of first store", storeCycle[0], 6);
	finishTest("resetState");
endtask

task automatic arithForwarding();
	int immA;
	int immB;
	word a;
	word b;
	word sum;
	word diff;
	word andV;
	word orV;
	immA = randImm();
	immB = randImm();
	a = signExt(immA);
	b = signExt(immB);
	sum = a + b;
	diff = a - sum;
	andV = diff & sum;
	orV = andV | b;
	newProgram();
	addInstr(iInstr(addi, 1, 0, immA));
	addInstr(iInstr(addi, 2, 0, immB));
	addInstr(rInstr(fAdd, 3, 1, 2));                          // Both operands forwarded
	addInstr(rInstr(fSub, 4, 1, 3));
	addInstr(rInstr(fAnd, 5, 4, 3));
	addInstr(rInstr(fOr, 6, 5, 2));
	addInstr(rInstr(fSlt, 7, 6, 4));
	addInstr(iInstr(sw, 7, 0, 0));                            // Store data from memory stage
	addInstr(rInstr(fSlt, 8, 2, 1));
	addInstr(iInstr(sw, 3, 0, 4));
	addInstr(iInstr(sw, 4, 0, 8));
	addInstr(iInstr(sw, 5, 0, 12));
	addInstr(iInstr(sw, 6, 0, 16));
	addInstr(iInstr(sw, 8, 0, 20));
	expectStore(32'd0, sltOf(orV, diff));
	expectStore(32'd4, sum);
	expectStore(32'd8, diff);
	expectStore(32'd12, andV);
	expectStore(32'd16, orV);
	expectStore(32'd20, sltOf(b, a));
	runProgram("arith");
endtask

task automatic loadUseStall();
	int immA;
	int immB;
	word a;
	word b;
	immA = randImm();
	immB = randImm();
	a = signExt(immA);
	b = signExt(immB);
	newProgram();
	addInstr(iInstr(addi, 1, 0, immA));
	addInstr(iInstr(addi, 2, 0, immB));
	addInstr(iInstr(sw, 1, 0, 32));
	addInstr(iInstr(lw, 3, 0, 32));
	addInstr(rInstr(fAdd, 4, 3, 2));                          // Stalls on rs
	addInstr(iInstr(sw, 4, 0, 36));
	addInstr(iInstr(lw, 5, 0, 36));
	addInstr(rInstr(fSub, 6, 2, 5));                          // Stalls on rt
	addInstr(iInstr(sw, 6, 0, 40));
	addInstr(iInstr(lw, 7, 0, 32));
	addInstr(iInstr(sw, 7, 0, 44));                           // Store of the loaded word
	expectStore(32'd32, a);
	expectStore(32'd36, a + b);
	expectStore(32'd40, b - (a + b));
	expectStore(32'd44, a);
	runProgram("loadUse");
endtask

task automatic takenBranchFlush();
	int immA;
	word a;
	immA = randImm();
	a = signExt(immA);
	newProgram();
	addInstr(iInstr(addi, 1, 0, immA));
	addInstr(rInstr(fAdd, 2, 1, 0));
	addInstr(iInstr(beq, 2, 1, 4));                           // Target is slot 7
	addInstr(iInstr(sw, 1, 0, 64));
	addInstr(iInstr(sw, 1, 0, 68));
	addInstr(iInstr(sw, 1, 0, 72));
	addInstr(iInstr(sw, 1, 0, 76));
	addInstr(iInstr(sw, 2, 0, 80));
	addInstr(iInstr(addi, 3, 2, 5));
	addInstr(iInstr(sw, 3, 0, 84));
	expectStore(32'd80, a);
	expectStore(32'd84, a + 32'd5);
	runProgram("takenBranch");
endtask

task automatic untakenBranchFallThrough();
	int immA;
	int immB;
	word a;
	word b;
	immA = randImm();
	immB = (immA + 1) & 32'h0000FFFF;                         // Always differs from immA
	a = signExt(immA);
	b = signExt(immB);
	newProgram();
	addInstr(iInstr(addi, 1, 0, immA));
	addInstr(iInstr(addi, 2, 0, immB));
	addInstr(iInstr(beq, 2, 1, 3));
	addInstr(iInstr(sw, 1, 0, 96));
	addInstr(iInstr(sw, 2, 0, 100));
	addInstr(rInstr(fSub, 3, 1, 2));
	addInstr(iInstr(sw, 3, 0, 104));
	expectStore(32'd96, a);
	expectStore(32'd100, b);
	expectStore(32'd104, a - b);
	runProgram("untakenBranch");
endtask

task automatic registerZeroWrites();
	int immA;
	int immB;
	word a;
	immA = randImm();
	immB = randImm() | 1;
	a = signExt(immA);
	newProgram();
	addInstr(iInstr(addi, 1, 0, immA));
	addInstr(iInstr(addi, 0, 0, immB));                       // Write to r0 is dropped
	addInstr(iInstr(sw, 0, 0, 128));
	addInstr(rInstr(fAdd, 2, 0, 1));
	addInstr(rInstr(fSub, 3, 0, 1));
	addInstr(iInstr(sw, 2, 0, 132));
	addInstr(iInstr(sw, 3, 0, 136));
	addInstr(rInstr(fAdd, 0, 1, 1));
	addInstr(rInstr(fOr, 4, 0, 0));
	addInstr(iInstr(sw, 4, 0, 140));
	addInstr(rInstr(fSlt, 5, 0, 1));
	addInstr(iInstr(sw, 5, 0, 144));
	expectStore(32'd128, 32'd0);
	expectStore(32'd132, a);
	expectStore(32'd136, 32'd0 - a);
	expectStore(32'd140, 32'd0);
	expectStore(32'd144, sltOf(32'd0, a));
	runProgram("regZero");
endtask

`endif

//--- dv/mipsCoreTb.sv
// Testbench top for the pipelined MIPS core
// Clock, reset, instruction and data memory models, compare tasks and summary
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam int memWords = 256;
	localparam int seed = 63571;
	localparam int cycleLimit = 200;
	localparam int pipeDepth = 5;
	localparam int resetCycles = 16;

	logic clk;
	logic reset;
	word pc;
	word instr;
	logic memWrite;
	word dataAddr;
	word writeData;
	word readData;

	word imem [0:memWords-1];
	word dmem [0:memWords-1];
	word storeAddr [$];                                       // Observed stores in order
	word storeData [$];
	int storeCycle [$];
	word expAddr [$];                                         // Expected stores in order
	word expData [$];
	int cycleCount;
	int progLen;
	int testErrors;
	int errorCount;
	int testCount;

	mipsCore dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.memWrite(memWrite),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.readData(readData)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ******************************************************************
	// Memory models
	// ******************************************************************

	assign instr = imem[pc[9:2]];                             // Combinational fetch
	assign readData = dmem[dataAddr[9:2]];

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < memWords; i++)
				dmem[i] <= word'(i) * 32'h9E3779B1;               // Fill varies with every address bit
			storeAddr.delete();
			storeData.delete();
			storeCycle.delete();
			cycleCount <= 0;
		end
		else
		begin
			cycleCount <= cycleCount + 1;
			if (memWrite)
			begin
				dmem[dataAddr[9:2]] <= writeData;
				storeAddr.push_back(dataAddr);
				storeData.push_back(writeData);
				storeCycle.push_back(cycleCount);             // Cycle in which memWrite was high
			end
		end
	end

	// ******************************************************************
	// Compare tasks
	// ******************************************************************

	task automatic checkWord(input string name, input word actual, input word expected);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
			testErrors++;
		end
	endtask

	task automatic checkCount(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			testErrors++;
		end
	endtask

	`include "mipsTbTasks.svh"

	initial
	begin
		reset = 1'b1;
		errorCount = 0;
		testCount = 0;
		testErrors = 0;
		progLen = 0;
		void'($urandom(seed));
		newProgram();
		resetAndFirstStore();
		arithForwarding();
		loadUseStall();
		takenBranchFlush();
		untakenBranchFallThrough();
		registerZeroWrites();
		if (dut.pipeCheck.assertFails != 0)
		begin
			$display("The checker saw %0d assertion failures", dut.pipeCheck.assertFails);
			errorCount += dut.pipeCheck.assertFails;
		end
		$display("Summary: %0d tests, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsPipe.f
+incdir+include
verilog/mipsPkg.sv
verilog/regFile.sv
verilog/mipsDecode.sv
verilog/mipsExecute.sv
verilog/mipsResult.sv
verilog/hazardUnit.sv
verilog/mipsCore.sv
dv/mipsCoreChecker.sv
dv/mipsCoreTb.sv

//--- Makefile
TOP := mipsCoreTb
SOURCES := $(shell grep '\.sv$$' mipsPipe.f) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
obj_dir/V$(TOP): mipsPipe.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mipsPipe.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
